// File: labrun_map_pkg.sv
/*
  main-board memory map and bus vector types
  shared by the CPU glue, work RAM, top level and testbench
*/
package labrun_map_pkg;

    localparam int RAM_AW = 11;   // 2 KB work RAM

    typedef logic [15:0]       addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [2:0]        bank_t;
    typedef logic [16:0]       rom_addr_t;
    typedef logic [13:0]       gfx_addr_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;

    // region prefixes, matched against the top address bits
    localparam logic [4:0] PAL_PFX = 5'b00010;   // 1000-17ff, addr[15:11]
    localparam logic [4:0] RAM_PFX = 5'b00011;   // 1800-1fff, addr[15:11]
    localparam logic [2:0] GFX_PFX = 3'b001;     // 2000-3fff, addr[15:13]
    localparam logic [7:0] CFG_PFX = 8'h00;      // 0000-00ff, addr[15:8]

    // I/O page 08xx-0fxx, device picked by addr[10:8]
    localparam logic [4:0] IO_PFX  = 5'b00001;
    localparam logic [2:0] IO_IN   = 3'd2;       // cabinet inputs
    localparam logic [2:0] IO_SYS  = 3'd3;       // coin and service
    localparam logic [2:0] IO_BANK = 3'd4;       // ROM bank register
    localparam logic [2:0] IO_PROT = 3'd5;       // protection coprocessor

    // ROM bank window sits two banks above the fixed upper half
    localparam logic [2:0] BANK_OFS = 3'd2;

    localparam logic [7:0] IDLE_BYTE = 8'hff;    // open bus

endpackage

// File: labrun_prot_pkg.sv
/*
  register map and types of the protection coprocessor
  operands are written in bytes, results read back in bytes
*/
package labrun_prot_pkg;

    typedef logic [15:0] prot_word_t;
    typedef logic [4:0]  prot_reg_t;

    // write side
    localparam prot_reg_t PROT_A_HI = 5'd0;
    localparam prot_reg_t PROT_A_LO = 5'd1;
    localparam prot_reg_t PROT_B_HI = 5'd2;
    localparam prot_reg_t PROT_B_LO = 5'd3;

    // read side, offsets shared with the operand writes
    localparam prot_reg_t PROT_Q_HI = 5'd0;   // quotient
    localparam prot_reg_t PROT_Q_LO = 5'd1;
    localparam prot_reg_t PROT_R_HI = 5'd2;   // remainder
    localparam prot_reg_t PROT_R_LO = 5'd3;
    localparam prot_reg_t PROT_P_HI = 5'd4;   // product, low word only
    localparam prot_reg_t PROT_P_LO = 5'd5;

    // quotient reported for a zero divisor
    localparam prot_word_t DIV0_QUOT = 16'hffff;

endpackage

// File: labrun_main.sv
/*
  main CPU glue logic: address decode, ROM banking, graphics address,
  cabinet ports, read-data multiplexer and raster interrupt latch
*/
`timescale 1ns/100ps

module labrun_main (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_cen,
    // CPU bus
    input  labrun_map_pkg::addr_t     addr,
    input  logic                      rnw,
    input  labrun_map_pkg::byte_t     cpu_dout,
    output labrun_map_pkg::byte_t     cpu_din,
    output logic                      irq_n,
    input  logic                      irq_ack,
    // ROM
    output labrun_map_pkg::rom_addr_t rom_addr,
    output logic                      rom_cs,
    input  labrun_map_pkg::byte_t     rom_data,
    // on-board devices
    output logic                      ram_we,
    output labrun_map_pkg::ram_addr_t ram_addr,
    input  labrun_map_pkg::byte_t     ram_dout,
    output logic                      prot_we,
    output logic                      prot_re,
    output labrun_prot_pkg::prot_reg_t prot_addr,
    input  labrun_map_pkg::byte_t     prot_dout,
    // graphics
    output labrun_map_pkg::gfx_addr_t gfx_addr,
    output logic                      gfx_cs,
    output logic                      pal_cs,
    input  labrun_map_pkg::byte_t     gfx_dout,
    input  labrun_map_pkg::byte_t     pal_dout,
    input  logic                      gfx_irqn,
    input  logic                      dip_pause,
    // cabinet
    input  logic [1:0]                start_button,
    input  logic [1:0]                coin_input,
    input  logic [5:0]                joystick1,
    input  logic [5:0]                joystick2,
    input  logic                      service
);
    import labrun_map_pkg::*;

    logic  ram_cs, io_page, io_rd;
    logic  in_cs, sys_cs, bank_cs, prot_cs;
    logic  pre_gfx, pre_cfg;
    logic  last_irqn, irq_fall;
    bank_t bank;
    byte_t joy_sel, cabinet, sys_dout, port_in;

    always_comb begin
        rom_cs  = (addr[15] || addr[15:14] == 2'b01) && rnw;
        ram_cs  = addr[15:11] == RAM_PFX;
        pal_cs  = addr[15:11] == PAL_PFX;
        pre_gfx = addr[15:13] == GFX_PFX;
        pre_cfg = addr[15:8] == CFG_PFX;   // chip configuration page
        io_page = addr[15:11] == IO_PFX;
        in_cs   = 1'b0;
        sys_cs  = 1'b0;
        bank_cs = 1'b0;
        prot_cs = 1'b0;
        if (io_page) begin
            case (addr[10:8])
                IO_IN:   in_cs   = rnw;
                IO_SYS:  sys_cs  = rnw;
                IO_BANK: bank_cs = !rnw;  // write only
                IO_PROT: prot_cs = 1'b1;
                default: ;                // sound and watchdog not fitted
            endcase
        end
    end

    assign io_rd     = io_page && rnw;
    assign ram_we    = ram_cs && !rnw && cpu_cen;
    assign ram_addr  = addr[RAM_AW-1:0];
    assign prot_we   = prot_cs && !rnw;
    assign prot_re   = prot_cs && rnw;
    assign prot_addr = addr[4:0];

    // upper half is fixed, 4000-7fff is the banked window
    assign rom_addr = addr[15] ? {2'b00, addr[14:0]} : {bank + BANK_OFS, addr[13:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else if (cpu_cen && bank_cs) begin
            bank <= cpu_dout[2:0];
        end
    end

    // graphics chip sees its address one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_cs <= 1'b0;
        end else begin
            gfx_cs <= pre_gfx | pre_cfg;
        end
    end

    always_ff @(posedge clk) begin
        gfx_addr <= {pre_gfx, ~addr[12], addr[11:0]};
    end

    // button bits come in a scrambled order on the edge connector
    assign joy_sel  = addr[0] ? {2'b00, joystick1} : {2'b00, joystick2};
    assign sys_dout = {5'b11111, service, coin_input};

    always_ff @(posedge clk) begin
        cabinet <= {2'b11, joy_sel[5:4], joy_sel[2], joy_sel[3], joy_sel[0], joy_sel[1]};
        if (in_cs) begin
            port_in <= cabinet;
        end else if (sys_cs) begin
            port_in <= sys_dout;
        end else if (prot_re) begin
            port_in <= prot_dout;
        end else begin
            port_in <= IDLE_BYTE;
        end
    end

    always_comb begin
        case (1'b1)
            rom_cs:  cpu_din = rom_data;
            ram_cs:  cpu_din = ram_dout;
            pal_cs:  cpu_din = pal_dout;
            io_rd:   cpu_din = port_in;   // two register stages
            gfx_cs:  cpu_din = gfx_dout;
            default: cpu_din = IDLE_BYTE;
        endcase
    end

    // raster interrupt, set on gfx_irqn fall and held until acknowledged
    assign irq_fall = last_irqn && !gfx_irqn && dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_irqn <= 1'b1;
            irq_n     <= 1'b1;
        end else begin
            last_irqn <= gfx_irqn;
            if (irq_ack) begin
                irq_n <= 1'b1;    // ack wins over a new edge
            end else if (irq_fall) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

// File: labrun_ram.sv
/*
  2 KB main CPU work RAM
  byte writes on ram_we, read data registered with one cycle of latency
*/
`timescale 1ns/100ps

module labrun_ram (
    input  logic                      clk,
    input  logic                      ram_we,
    input  labrun_map_pkg::ram_addr_t ram_addr,
    input  labrun_map_pkg::byte_t     din,
    output labrun_map_pkg::byte_t     dout
);
    import labrun_map_pkg::*;

    localparam int DEPTH = 2 ** RAM_AW;

    byte_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= din;
        end
    end

    // read old data during a write, like the board SRAM
    always_ff @(posedge clk) begin
        dout <= mem[ram_addr];
    end

endmodule

// File: labrun_prot.sv
/*
  protection coprocessor, a small divide and multiply unit
  the CPU writes two 16-bit operands a byte at a time, then reads
  quotient, remainder and product bytes through a registered port
*/
`timescale 1ns/100ps

module labrun_prot (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_cen,
    input  logic                       prot_we,
    input  logic                       prot_re,
    input  labrun_prot_pkg::prot_reg_t prot_addr,
    input  labrun_map_pkg::byte_t      din,
    output labrun_map_pkg::byte_t      dout
);
    import labrun_map_pkg::*;
    import labrun_prot_pkg::*;

    prot_word_t op_a, op_b;
    prot_word_t quot, rem, prod;
    logic       div0;
    byte_t      rd_byte;

    // operand registers, big-endian byte order
    always_ff @(posedge clk) begin
        if (rst) begin
            op_a <= '0;
            op_b <= '0;
        end else if (cpu_cen && prot_we) begin
            case (prot_addr)
                PROT_A_HI: op_a[15:8] <= din;
                PROT_A_LO: op_a[7:0]  <= din;
                PROT_B_HI: op_b[15:8] <= din;
                PROT_B_LO: op_b[7:0]  <= din;
                default:   ;   // other offsets ignore writes
            endcase
        end
    end

    assign div0 = op_b == '0;

    // results follow the operands without a start strobe
    always_comb begin
        if (div0) begin
            quot = DIV0_QUOT;
            rem  = op_a;       // nothing taken away
        end else begin
            quot = op_a / op_b;
            rem  = op_a % op_b;
        end
    end

    // only the low word of the product is visible
    logic [31:0] prod_full;

    assign prod_full = op_a * op_b;
    assign prod      = prod_full[15:0];

    always_comb begin
        case (prot_addr)
            PROT_Q_HI: rd_byte = quot[15:8];
            PROT_Q_LO: rd_byte = quot[7:0];
            PROT_R_HI: rd_byte = rem[15:8];
            PROT_R_LO: rd_byte = rem[7:0];
            PROT_P_HI: rd_byte = prod[15:8];
            PROT_P_LO: rd_byte = prod[7:0];
            default:   rd_byte = IDLE_BYTE;
        endcase
    end

    // read port, one cycle of latency
    always_ff @(posedge clk) begin
        if (prot_re) begin
            dout <= rd_byte;
        end else begin
            dout <= IDLE_BYTE;   // floats high when not selected
        end
    end

endmodule

// File: labrun_top.sv
/*
  main board bus logic: CPU glue, work RAM and protection chip
  the CPU bus, ROM, graphics and cabinet signals are top-level ports
*/
`timescale 1ns/100ps

module labrun_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_cen,
    input  labrun_map_pkg::addr_t     addr,
    input  logic                      rnw,
    input  labrun_map_pkg::byte_t     cpu_dout,
    output labrun_map_pkg::byte_t     cpu_din,
    output logic                      irq_n,
    input  logic                      irq_ack,
    output labrun_map_pkg::rom_addr_t rom_addr,
    output logic                      rom_cs,
    input  labrun_map_pkg::byte_t     rom_data,
    output labrun_map_pkg::gfx_addr_t gfx_addr,
    output logic                      gfx_cs,
    output logic                      pal_cs,
    input  labrun_map_pkg::byte_t     gfx_dout,
    input  labrun_map_pkg::byte_t     pal_dout,
    input  logic                      gfx_irqn,
    input  logic                      dip_pause,
    input  logic [1:0]                start_button,
    input  logic [1:0]                coin_input,
    input  logic [5:0]                joystick1,
    input  logic [5:0]                joystick2,
    input  logic                      service
);
    import labrun_map_pkg::*;
    import labrun_prot_pkg::*;

    logic      ram_we, prot_we, prot_re;
    ram_addr_t ram_addr;
    prot_reg_t prot_addr;
    byte_t     ram_dout, prot_dout;

    labrun_main u_main (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen),
        .addr(addr), .rnw(rnw), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
        .irq_n(irq_n), .irq_ack(irq_ack),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .ram_we(ram_we), .ram_addr(ram_addr), .ram_dout(ram_dout),
        .prot_we(prot_we), .prot_re(prot_re), .prot_addr(prot_addr),
        .prot_dout(prot_dout),
        .gfx_addr(gfx_addr), .gfx_cs(gfx_cs), .pal_cs(pal_cs),
        .gfx_dout(gfx_dout), .pal_dout(pal_dout),
        .gfx_irqn(gfx_irqn), .dip_pause(dip_pause),
        .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service)
    );

    labrun_ram u_ram (
        .clk(clk), .ram_we(ram_we), .ram_addr(ram_addr),
        .din(cpu_dout), .dout(ram_dout)
    );

    labrun_prot u_prot (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen),
        .prot_we(prot_we), .prot_re(prot_re), .prot_addr(prot_addr),
        .din(cpu_dout), .dout(prot_dout)
    );

endmodule

// File: tb_labrun.sv
/*
  testbench for the main board bus logic, acting as the CPU on its bus
  checks work RAM, ROM banking, cabinet ports, protection, graphics decode and irq
*/
`timescale 1ns/100ps

module tb_labrun;
    import labrun_map_pkg::*;
    import labrun_prot_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int RAM_WRITES   = 64;
    localparam int CAB_ROUNDS   = 8;
    localparam int PROT_PAIRS   = 12;
    localparam int GFX_PER_AREA = 8;
    // one bus cycle per write and two per read
    localparam int RAM_CYCLES  = RAM_WRITES * 3;
    localparam int BANK_CYCLES = 8 * 5;
    localparam int CAB_CYCLES  = CAB_ROUNDS * 6 + 4;
    localparam int PROT_CYCLES = PROT_PAIRS * 16;
    localparam int GFX_CYCLES  = GFX_PER_AREA * 3 * 2;
    localparam int IRQ_CYCLES  = 12;
    localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + RAM_CYCLES + BANK_CYCLES
                                         + CAB_CYCLES + PROT_CYCLES + GFX_CYCLES + IRQ_CYCLES);

    localparam byte_t GFX_PATTERN = 8'h5a;
    localparam byte_t PAL_PATTERN = 8'hc3;

    logic       clk = 1'b0;
    logic       rst, cpu_cen, rnw, irq_ack, irq_n;
    logic       rom_cs, gfx_cs, pal_cs, gfx_irqn, dip_pause, service;
    logic [1:0] start_button, coin_input;
    logic [5:0] joystick1, joystick2;
    addr_t      addr;
    byte_t      cpu_dout, cpu_din, rom_data, gfx_dout, pal_dout;
    rom_addr_t  rom_addr;
    gfx_addr_t  gfx_addr;

    // model state
    byte_t       ram_model [0:2047];
    bank_t       model_bank = '0;
    prot_word_t  model_a = '0;
    prot_word_t  model_b = '0;
    logic [31:0] lfsr_state = 32'h16ab;
    int          checks = 0;
    int          errors = 0;
    int          first_check, first_error;
    int          cycles = 0;
    string       cur_test;

    labrun_top dut0 (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen),
        .addr(addr), .rnw(rnw), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
        .irq_n(irq_n), .irq_ack(irq_ack),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .gfx_addr(gfx_addr), .gfx_cs(gfx_cs), .pal_cs(pal_cs),
        .gfx_dout(gfx_dout), .pal_dout(pal_dout),
        .gfx_irqn(gfx_irqn), .dip_pause(dip_pause),
        .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service)
    );

    always #4 clk = ~clk;

    function automatic byte_t rom_pattern(input rom_addr_t ra);
        return ra[7:0] ^ ra[16:9];
    endfunction

    // ROM model answers at once and never stalls the CPU
    assign rom_data = rom_cs ? rom_pattern(rom_addr) : 8'h00;
    assign gfx_dout = GFX_PATTERN;
    assign pal_dout = PAL_PATTERN;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic rom_addr_t expected_rom_addr(input addr_t a);
        return a[15] ? {2'b00, a[14:0]} : {bank_t'(model_bank + 3'd2), a[13:0]};
    endfunction

    function automatic byte_t cabinet_byte(input logic [5:0] j);
        return {2'b11, j[5], j[4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic byte_t prot_byte(input logic [4:0] ofs);
        prot_word_t  q, r;
        logic [31:0] p;
        q = (model_b == 0) ? DIV0_QUOT : model_a / model_b;
        r = (model_b == 0) ? model_a : model_a % model_b;
        p = {16'h0, model_a} * {16'h0, model_b};
        case (ofs)
            5'd0:    return q[15:8];
            5'd1:    return q[7:0];
            5'd2:    return r[15:8];
            5'd3:    return r[7:0];
            5'd4:    return p[15:8];
            5'd5:    return p[7:0];
            default: return IDLE_BYTE;
        endcase
    endfunction

    // what the CPU should see at address a in the current model state
    function automatic byte_t expected_read(input addr_t a);
        if (a[15:14] != 2'b00)
            return rom_pattern(expected_rom_addr(a));
        if (a[15:11] == 5'b00011)
            return ram_model[a[10:0]];
        if (a[15:11] == 5'b00010)
            return PAL_PATTERN;
        if (a[15:13] == 3'b001 || a[15:8] == 8'h00)
            return GFX_PATTERN;
        if (a[15:11] == 5'b00001) begin
            case (a[10:8])
                3'd2:    return cabinet_byte(a[0] ? joystick1 : joystick2);
                3'd3:    return {5'b11111, service, coin_input};
                3'd5:    return prot_byte(a[4:0]);
                default: return IDLE_BYTE;
            endcase
        end
        return IDLE_BYTE;
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gfx_addr(input string name, input gfx_addr_t exp, input gfx_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        first_check = checks;
        first_error = errors;
    endtask

    task automatic finish_test();
        $display("%s done, %0d checks, %0d errors", cur_test,
                 checks - first_check, errors - first_error);
    endtask

    // bus tasks start and end on a falling edge
    task automatic bus_write(input addr_t a, input byte_t d);
        addr     = a;
        rnw      = 1'b0;
        cpu_dout = d;
        cpu_cen  = 1'b1;
        @(negedge clk);
        cpu_cen = 1'b0;
        rnw     = 1'b1;
    endtask

    task automatic bus_read(input addr_t a, output byte_t d);
        addr = a;
        rnw  = 1'b1;
        repeat (2) @(negedge clk);   // data valid after the second rising edge
        d = cpu_din;
    endtask

    task automatic check_read(input addr_t a);
        byte_t d;
        bus_read(a, d);
        check_byte($sformatf("%s read %h", cur_test, a), expected_read(a), d);
    endtask

    task automatic ram_readback();
        addr_t written [$];
        addr_t a;
        byte_t d;
        start_test("ram");
        for (int i = 0; i < RAM_WRITES; i++) begin
            a = 16'h1800 | addr_t'(rand_bits(11));
            d = byte_t'(rand_bits(8));
            bus_write(a, d);
            ram_model[a[10:0]] = d;
            written.push_back(a);
        end
        foreach (written[i])
            check_read(written[i]);
        finish_test();
    endtask

    task automatic bank_switching();
        addr_t a;
        byte_t d;
        string label;
        start_test("bank");
        for (int b = 0; b < 8; b++) begin
            bus_write(16'h0c00 | addr_t'(rand_bits(8)), {5'(rand_bits(5)), 3'(b)});
            model_bank = 3'(b);
            for (int k = 0; k < 2; k++) begin
                // banked window first then the fixed upper half
                a = k ? 16'h8000 | addr_t'(rand_bits(15)) : 16'h4000 | addr_t'(rand_bits(14));
                bus_read(a, d);
                label = $sformatf("%s %0d read %h", cur_test, b, a);
                check_flag({label, " rom_cs"}, 1'b1, rom_cs);
                check_rom_addr(label, expected_rom_addr(a), rom_addr);
                check_byte(label, expected_read(a), d);
            end
        end
        finish_test();
    endtask

    task automatic cabinet_inputs();
        start_test("inputs");
        for (int i = 0; i < CAB_ROUNDS; i++) begin
            joystick1    = 6'(rand_bits(6));
            joystick2    = 6'(rand_bits(6));
            coin_input   = 2'(rand_bits(2));
            service      = 1'(rand_bits(1));
            start_button = 2'(rand_bits(2));
            check_read({8'h0a, 7'(rand_bits(7)), 1'b0});   // player 2
            check_read({8'h0a, 7'(rand_bits(7)), 1'b1});   // player 1
            check_read(16'h0b00 | addr_t'(rand_bits(8)));
        end
        check_read(16'h0800 | addr_t'(rand_bits(8)));      // unused I/O slots
        check_read(16'h0f00 | addr_t'(rand_bits(8)));
        finish_test();
    endtask

    task automatic prot_arithmetic();
        start_test("prot");
        for (int i = 0; i < PROT_PAIRS; i++) begin
            model_a = 16'(rand_bits(16));
            case (i % 4)
                0:       model_b = '0;
                1:       model_b = 16'(rand_bits(5));   // small divisor for a big quotient
                default: model_b = 16'(rand_bits(16));
            endcase
            bus_write(16'h0d00, model_a[15:8]);
            bus_write(16'h0d01, model_a[7:0]);
            bus_write(16'h0d02, model_b[15:8]);
            bus_write(16'h0d03, model_b[7:0]);
            for (int ofs = 0; ofs < 6; ofs++)
                check_read(16'h0d00 | addr_t'(ofs));
        end
        finish_test();
    endtask

    task automatic gfx_decode();
        addr_t a;
        byte_t d;
        string label;
        start_test("gfx");
        for (int i = 0; i < 3 * GFX_PER_AREA; i++) begin
            case (i % 3)
                0:       a = addr_t'(rand_bits(8));                // chip config page
                1:       a = 16'h1000 | addr_t'(rand_bits(11));    // palette
                default: a = 16'h2000 | addr_t'(rand_bits(13));
            endcase
            bus_read(a, d);
            label = $sformatf("%s read %h", cur_test, a);
            check_byte(label, expected_read(a), d);
            check_flag({label, " rom_cs"}, 1'b0, rom_cs);
            check_flag({label, " pal_cs"}, a[15:11] == 5'b00010, pal_cs);
            check_flag({label, " gfx_cs"}, a[15:13] == 3'b001 || a[15:8] == 8'h00, gfx_cs);
            check_gfx_addr(label, {a[15:13] == 3'b001, ~a[12], a[11:0]}, gfx_addr);
        end
        finish_test();
    endtask

    task automatic irq_latch();
        start_test("irq");
        gfx_irqn = 1'b0;   // raster line reached
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            check_flag("irq low after gfx_irqn fall", 1'b0, irq_n);
            @(negedge clk);
        end
        gfx_irqn = 1'b1;
        irq_ack  = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        check_flag("irq high after ack", 1'b1, irq_n);
        dip_pause = 1'b0;
        gfx_irqn  = 1'b0;
        repeat (2) @(negedge clk);
        check_flag("irq fall with dip_pause low", 1'b1, irq_n);
        gfx_irqn  = 1'b1;
        dip_pause = 1'b1;
        finish_test();
    endtask

    // run limit at four times the bus cycles of all tests
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, tests still running after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        cpu_cen      = 1'b0;
        rnw          = 1'b1;
        irq_ack      = 1'b0;
        addr         = '0;
        cpu_dout     = '0;
        gfx_irqn     = 1'b1;
        dip_pause    = 1'b1;
        service      = 1'b0;
        start_button = '0;
        coin_input   = '0;
        joystick1    = '0;
        joystick2    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        start_test("reset");
        check_flag("reset irq_n", 1'b1, irq_n);
        check_flag("reset gfx_cs", 1'b0, gfx_cs);
        finish_test();
        rst = 1'b0;
        ram_readback();
        bank_switching();
        cabinet_inputs();
        prot_arithmetic();
        gfx_decode();
        irq_latch();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
labrun_map_pkg.sv
labrun_prot_pkg.sv
labrun_main.sv
labrun_ram.sv
labrun_prot.sv
labrun_top.sv
tb_labrun.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_labrun
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
